//--- rtl/frame_wr_pkg.sv
// Shared widths, memory map and types for the frame buffer writer.
// The memory map assumes N_CH regions of CH_REGION each, every region
// holding two frame areas FRAME_OFFSET apart. A running offset that
// grows past FRAME_OFFSET spills into the next area, so the line buffers
// must not push more than one frame's worth of bursts per vsync.
package frame_wr_pkg;

    localparam int N_CH = 4; // buffer channels
    localparam int DATA_W = 256; // AXI beat width
    localparam int ADDR_W = 28; // AXI address width
    localparam int BURST_LEN = 16; // beats per burst

    // one address unit per 32-bit DDR word, eight words per beat
    localparam int ADDR_STEP = BURST_LEN * 8;

    localparam int FRAME_OFFSET = 30000; // ping-pong area spacing
    localparam int CH_REGION = 2 * FRAME_OFFSET; // per-channel region size
    localparam int OFFSET_W = 20; // running offset width
    localparam int INIT_BURSTS = 4; // start-up bursts per channel

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [$clog2(N_CH)-1:0] ch_idx_t;
    typedef logic [N_CH-1:0] ch_mask_t;
    typedef logic [3:0] beat_t; // holds 0 to BURST_LEN-1

endpackage

//--- rtl/vsync_frame_tracker.sv
// One channel's vsync handling.
// vsync may be asynchronous to clk; it is re-timed through two flops.
// frame_start pulses one cycle per rising edge, and frame_sel flips on
// the cycle after. frame_sel starts at 1 so the first frame lands in area 0.
// vsync must stay low for at least two clocks between frames.
module vsync_frame_tracker (
    input  logic clk,
    input  logic rst,
    input  logic vsync,
    output logic frame_start,
    output logic frame_sel
);

    logic vs_meta;
    logic vs_sync;
    logic vs_last;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vs_meta <= 1'b0;
            vs_sync <= 1'b0;
            vs_last <= 1'b0;
        end else begin
            vs_meta <= vsync; // first sync stage
            vs_sync <= vs_meta;
            vs_last <= vs_sync; // previous value for edge detect
        end
    end

    assign frame_start = vs_sync & ~vs_last; // rising edge only

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            frame_sel <= 1'b1; // toggled to area 0 by the first vsync
        end else if (frame_start) begin
            frame_sel <= ~frame_sel;
        end
    end

endmodule

//--- rtl/write_addr_tracker.sv
// Burst address generation for all channels.
// awaddr follows cur_ch combinationally, so it is only meaningful while
// the scheduler has a burst address pending. A frame_start on the channel
// being addressed changes awaddr at once; vsync is expected between
// bursts of that channel. init_done is sticky until reset.
module write_addr_tracker (
    input  logic                  clk,
    input  logic                  rst,
    input  frame_wr_pkg::ch_mask_t frame_start,
    input  frame_wr_pkg::ch_mask_t frame_sel,
    input  frame_wr_pkg::ch_idx_t  cur_ch,
    input  logic                  aw_fire,
    output frame_wr_pkg::addr_t    awaddr,
    output logic                  init_done
);

    frame_wr_pkg::offset_t offset [frame_wr_pkg::N_CH]; // running offset per channel
    frame_wr_pkg::ch_mask_t filled;
    frame_wr_pkg::addr_t ch_base;
    frame_wr_pkg::addr_t area_base;

    // offsets restart on a new frame and step once per accepted address
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
                offset[i] <= '0;
            end
        end else begin
            for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
                if (frame_start[i]) begin
                    offset[i] <= '0; // new frame wins over a same-cycle burst
                end else if (aw_fire && (cur_ch == frame_wr_pkg::ch_idx_t'(i))) begin
                    offset[i] <= offset[i] + frame_wr_pkg::offset_t'(frame_wr_pkg::ADDR_STEP);
                end
            end
        end
    end

    always_comb begin
        ch_base = frame_wr_pkg::addr_t'(frame_wr_pkg::CH_REGION * cur_ch);
        if (frame_sel[cur_ch]) begin
            area_base = frame_wr_pkg::addr_t'(frame_wr_pkg::FRAME_OFFSET);
        end else begin
            area_base = '0;
        end
        awaddr = ch_base + area_base + frame_wr_pkg::addr_t'(offset[cur_ch]);
    end

    // a channel counts as filled once its start-up bursts are written
    always_comb begin
        for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
            filled[i] = offset[i] >= frame_wr_pkg::offset_t'(
                frame_wr_pkg::INIT_BURSTS * frame_wr_pkg::ADDR_STEP);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            init_done <= 1'b0;
        end else if (&filled) begin
            init_done <= 1'b1; // stays set through later frames
        end
    end

endmodule

//--- rtl/channel_scheduler.sv
// Round-robin burst scheduler over the line buffers.
// One burst is in flight at a time: address first, then BURST_LEN beats.
// Buffers are first-word-fall-through; buf_ready must mean a whole burst
// is present, since beats are popped without a per-word check.
// Write responses are not tracked and must be accepted by the far side.
module channel_scheduler (
    input  logic                   clk,
    input  logic                   rst,
    input  frame_wr_pkg::ch_mask_t buf_ready,
    input  frame_wr_pkg::data_t    buf_data [frame_wr_pkg::N_CH],
    input  logic                   awready,
    input  logic                   wready,
    output frame_wr_pkg::ch_idx_t  cur_ch,
    output logic                   aw_fire,
    output logic                   awvalid,
    output logic                   wvalid,
    output logic                   wlast,
    output frame_wr_pkg::data_t    wdata,
    output frame_wr_pkg::ch_mask_t buf_rd_en
);

    typedef enum logic [1:0] {
        SCAN,
        ADDR,
        DATA
    } state_t;

    state_t state;
    frame_wr_pkg::beat_t beat; // beats sent in the current burst
    frame_wr_pkg::ch_idx_t next_ch;
    logic w_fire;

    // wrap after the last channel, works for any N_CH
    always_comb begin
        if (cur_ch == frame_wr_pkg::ch_idx_t'(frame_wr_pkg::N_CH - 1)) begin
            next_ch = '0;
        end else begin
            next_ch = cur_ch + 1'b1;
        end
    end

    assign awvalid = (state == ADDR); // held until awready
    assign wvalid = (state == DATA);
    assign wlast = wvalid && (beat == frame_wr_pkg::beat_t'(frame_wr_pkg::BURST_LEN - 1));
    assign aw_fire = awvalid & awready;
    assign w_fire = wvalid & wready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= SCAN;
            cur_ch <= '0;
            beat <= '0;
        end else begin
            case (state)
                SCAN: begin
                    if (buf_ready[cur_ch]) begin
                        state <= ADDR;
                    end else begin
                        cur_ch <= next_ch; // one cycle per idle channel
                    end
                end
                ADDR: begin
                    if (aw_fire) begin
                        state <= DATA;
                        beat <= '0;
                    end
                end
                DATA: begin
                    if (w_fire) begin
                        beat <= beat + 1'b1; // stalls with wready
                        if (wlast) begin
                            state <= SCAN;
                            cur_ch <= next_ch;
                        end
                    end
                end
                default: begin
                    state <= SCAN;
                end
            endcase
        end
    end

    assign wdata = buf_data[cur_ch]; // fall-through word of the current buffer

    // pop exactly the word the slave takes
    always_comb begin
        buf_rd_en = '0;
        if (state == DATA) begin
            buf_rd_en[cur_ch] = wready;
        end
    end

endmodule

//--- rtl/frame_buf_writer.sv
// Multi-channel frame buffer writer toward DDR over AXI write channels.
// Only the address and data channels are driven; the response channel
// must be tied ready on the memory side. Bursts are fixed at BURST_LEN
// beats, incrementing, full strobe, single ID, handled by the interconnect.
// The end of each burst is marked by the wlast transfer.
module frame_buf_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  frame_wr_pkg::ch_mask_t buf_ready,
    input  frame_wr_pkg::data_t    buf_data [frame_wr_pkg::N_CH],
    input  frame_wr_pkg::ch_mask_t vsync,
    output frame_wr_pkg::ch_mask_t buf_rd_en,
    output frame_wr_pkg::addr_t    awaddr,
    output logic                   awvalid,
    input  logic                   awready,
    output frame_wr_pkg::beat_t    awlen,
    output frame_wr_pkg::data_t    wdata,
    output logic                   wvalid,
    input  logic                   wready,
    output logic                   wlast,
    output logic                   init_done
);

    frame_wr_pkg::ch_mask_t frame_start;
    frame_wr_pkg::ch_mask_t frame_sel;
    frame_wr_pkg::ch_idx_t cur_ch;
    logic aw_fire;

    assign awlen = frame_wr_pkg::beat_t'(frame_wr_pkg::BURST_LEN - 1); // AXI length is beats-1

    for (genvar i = 0; i < frame_wr_pkg::N_CH; i++) begin : g_vs
        vsync_frame_tracker u_vs (
            .clk         (clk),
            .rst         (rst),
            .vsync       (vsync[i]),
            .frame_start (frame_start[i]),
            .frame_sel   (frame_sel[i])
        );
    end

    write_addr_tracker u_addr (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .frame_sel   (frame_sel),
        .cur_ch      (cur_ch),
        .aw_fire     (aw_fire),
        .awaddr      (awaddr),
        .init_done   (init_done)
    );

    channel_scheduler u_sched (
        .clk       (clk),
        .rst       (rst),
        .buf_ready (buf_ready),
        .buf_data  (buf_data),
        .awready   (awready),
        .wready    (wready),
        .cur_ch    (cur_ch),
        .aw_fire   (aw_fire),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .wdata     (wdata),
        .buf_rd_en (buf_rd_en)
    );

endmodule

//--- bench/frame_buf_writer_assert.sv
// AXI write-side protocol checks, bound into the top level.
// All checks are disabled while reset is low.
module frame_buf_writer_assert (
    input logic                   clk,
    input logic                   rst,
    input frame_wr_pkg::addr_t    awaddr,
    input logic                   awvalid,
    input logic                   awready,
    input logic                   wvalid,
    input logic                   wready,
    input logic                   wlast,
    input frame_wr_pkg::ch_mask_t buf_rd_en
);
    timeunit 1ns;
    timeprecision 1ps;

    a_addr_held: assert property (@(posedge clk) disable iff (!rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awaddr or awvalid changed before the address transfer");

    a_rd_en_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(buf_rd_en) && (buf_rd_en == '0 || (wvalid && wready)))
        else $error("buf_rd_en not one-hot or popping without a data transfer");

    a_last_valid: assert property (@(posedge clk) disable iff (!rst)
        wlast |-> wvalid)
        else $error("wlast high without wvalid");

endmodule

//--- bench/frame_buf_writer_tb.sv
// Directed testbench for the frame buffer writer.
// Buffers are modelled as always holding a burst while their ready bit is
// set; each word carries its channel and a running word count.
// Expected addresses come from a model of the memory map kept per channel.
module frame_buf_writer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000; // well above the length of all tests

    logic clk;
    logic rst;
    frame_wr_pkg::ch_mask_t buf_ready;
    frame_wr_pkg::data_t buf_data [frame_wr_pkg::N_CH];
    frame_wr_pkg::ch_mask_t vsync;
    frame_wr_pkg::ch_mask_t buf_rd_en;
    frame_wr_pkg::addr_t awaddr;
    logic awvalid;
    logic awready = 1'b1;
    frame_wr_pkg::beat_t awlen;
    frame_wr_pkg::data_t wdata;
    logic wvalid;
    logic wready = 1'b1;
    logic wlast;
    logic init_done;

    int word_cnt [frame_wr_pkg::N_CH]; // words popped per buffer
    int exp_area [frame_wr_pkg::N_CH];
    int exp_off [frame_wr_pkg::N_CH];
    int exp_word [frame_wr_pkg::N_CH];
    int since_frame [frame_wr_pkg::N_CH]; // bursts since last vsync
    logic init_seen = 1'b0;
    frame_wr_pkg::addr_t aw_q [$];
    frame_wr_pkg::beat_t len_q [$];
    frame_wr_pkg::data_t beat_q [$];
    logic last_q [$];
    int aw_total = 0;
    int last_total = 0;
    int cycles = 0;
    logic stall_en = 1'b0;
    logic [31:0] lfsr_state = 32'h4770e6c3;

    frame_buf_writer dut0 (
        .clk       (clk),
        .rst       (rst),
        .buf_ready (buf_ready),
        .buf_data  (buf_data),
        .vsync     (vsync),
        .buf_rd_en (buf_rd_en),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .awlen     (awlen),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .wlast     (wlast),
        .init_done (init_done)
    );

    bind frame_buf_writer frame_buf_writer_assert u_assert (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wvalid    (wvalid),
        .wready    (wready),
        .wlast     (wlast),
        .buf_rd_en (buf_rd_en)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois form, taps for x^32+x^22+x^2+x+1
    function automatic logic take_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic frame_wr_pkg::data_t make_word(input int ch, input int n);
        frame_wr_pkg::data_t w;
        w = '0;
        w[63:32] = ch;
        w[31:0] = n;
        w[frame_wr_pkg::DATA_W-1 -: 32] = ~n; // top lane differs per word too
        return w;
    endfunction

    always_comb begin
        for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
            buf_data[i] = make_word(i, word_cnt[i]); // fall-through head word
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
                word_cnt[i] <= 0;
            end
        end else begin
            for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
                if (buf_rd_en[i]) begin
                    word_cnt[i] <= word_cnt[i] + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (stall_en) begin
            awready <= take_bit() | take_bit(); // ready about 3 cycles in 4
            wready <= take_bit() | take_bit();
        end else begin
            awready <= 1'b1;
            wready <= 1'b1;
        end
    end

    // memory side, records every transfer
    always @(posedge clk) begin
        if (awvalid && awready) begin
            aw_q.push_back(awaddr);
            len_q.push_back(awlen);
            aw_total++;
        end
        if (wvalid && wready) begin
            beat_q.push_back(wdata);
            last_q.push_back(wlast);
            if (wlast) begin
                last_total++;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the tests did not finish in time");
        end
    end

    task automatic check_addr(input string name, input frame_wr_pkg::addr_t exp,
                              input frame_wr_pkg::addr_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run("wrong burst address");
        end
    endtask

    task automatic check_len(input string name, input frame_wr_pkg::beat_t exp,
                             input frame_wr_pkg::beat_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            abort_run("wrong burst length");
        end
    endtask

    task automatic check_data(input string name, input frame_wr_pkg::data_t exp,
                              input frame_wr_pkg::data_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run("wrong data word");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run("wrong flag value");
        end
    endtask

    task automatic check_init(input string name);
        logic all_filled;
        all_filled = 1'b1;
        for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
            if (since_frame[i] < frame_wr_pkg::INIT_BURSTS) begin
                all_filled = 1'b0;
            end
        end
        init_seen = init_seen | all_filled; // sticky
        check_flag({name, " init_done"}, init_seen, init_done);
    endtask

    task automatic pulse_vsync(input int ch);
        @(posedge clk);
        vsync[ch] <= 1'b1;
        repeat (3) @(posedge clk);
        vsync[ch] <= 1'b0;
        repeat (4) @(posedge clk); // frame_start and frame_sel settled
        exp_area[ch] = 1 - exp_area[ch];
        exp_off[ch] = 0;
        since_frame[ch] = 0;
    endtask

    task automatic check_bursts(input string name, input frame_wr_pkg::ch_mask_t mask,
                                input int n);
        frame_wr_pkg::addr_t addr;
        int ch;
        if (aw_q.size() != n || beat_q.size() != n * frame_wr_pkg::BURST_LEN) begin
            abort_run("address or beat count does not match the bursts sent");
        end
        ch = 0;
        for (int b = 0; b < n; b++) begin
            addr = aw_q.pop_front();
            if ($onehot(mask)) begin
                ch = $clog2(mask);
            end else if (b == 0) begin
                ch = int'(addr) / frame_wr_pkg::CH_REGION; // scan position is free
            end else begin
                ch = (ch + 1) % frame_wr_pkg::N_CH;
            end
            if (ch >= frame_wr_pkg::N_CH) begin
                abort_run("burst address lies outside every channel region");
            end
            check_addr(name, frame_wr_pkg::addr_t'(ch * frame_wr_pkg::CH_REGION
                + exp_area[ch] * frame_wr_pkg::FRAME_OFFSET + exp_off[ch]), addr);
            check_len({name, " awlen"}, frame_wr_pkg::beat_t'(frame_wr_pkg::BURST_LEN - 1),
                      len_q.pop_front());
            exp_off[ch] += frame_wr_pkg::ADDR_STEP;
            since_frame[ch]++;
            for (int k = 0; k < frame_wr_pkg::BURST_LEN; k++) begin
                check_data(name, make_word(ch, exp_word[ch]), beat_q.pop_front());
                check_flag({name, " wlast"}, k == frame_wr_pkg::BURST_LEN - 1,
                           last_q.pop_front());
                exp_word[ch]++;
            end
        end
        for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
            check_data({name, " pops"}, make_word(i, exp_word[i]), buf_data[i]);
        end
    endtask

    task automatic run_bursts(input string name, input frame_wr_pkg::ch_mask_t mask,
                              input int n);
        int target;
        target = aw_total + n;
        @(posedge clk);
        buf_ready <= mask;
        while (aw_total < target) @(negedge clk);
        @(posedge clk);
        buf_ready <= '0; // last burst is already in its data phase
        while (last_total < aw_total) @(negedge clk);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bursts(name, mask, n);
        check_init(name);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_flag("reset awvalid", 1'b0, awvalid);
        check_flag("reset wvalid", 1'b0, wvalid);
        check_flag("reset wlast", 1'b0, wlast);
        check_flag("reset buf_rd_en", 1'b0, |buf_rd_en);
        check_flag("reset init_done", 1'b0, init_done);
    endtask

    task automatic test_single_channel();
        pulse_vsync(2);
        run_bursts("single_channel", 4'b0100, 1);
    endtask

    task automatic test_round_robin();
        pulse_vsync(0);
        pulse_vsync(1);
        pulse_vsync(3);
        stall_en <= 1'b1;
        run_bursts("round_robin", '1, 8);
    endtask

    task automatic test_frame_switch();
        pulse_vsync(1); // channel 1 moves to its second area
        run_bursts("frame_switch", '1, 4);
    endtask

    task automatic test_startup_flag();
        repeat (3) begin
            run_bursts("startup_flag", '1, 4);
        end
        check_flag("startup_flag reached", 1'b1, init_done);
        pulse_vsync(0);
        @(negedge clk);
        check_flag("startup_flag after vsync", 1'b1, init_done);
    endtask

    initial begin
        rst = 1'b0;
        buf_ready = '0;
        vsync = '0;
        for (int i = 0; i < frame_wr_pkg::N_CH; i++) begin
            exp_area[i] = 1; // first vsync selects area 0
            exp_off[i] = 0;
            exp_word[i] = 0;
            since_frame[i] = 0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        test_reset();
        test_single_channel();
        test_round_robin();
        test_frame_switch();
        test_startup_flag();
        $display("TEST OK");
        $finish;
    end

endmodule

//--- compile.f
rtl/frame_wr_pkg.sv
rtl/vsync_frame_tracker.sv
rtl/write_addr_tracker.sv
rtl/channel_scheduler.sv
rtl/frame_buf_writer.sv
bench/frame_buf_writer_assert.sv
bench/frame_buf_writer_tb.sv

//--- Makefile
BIN = obj_dir/Vframe_buf_writer_tb

.PHONY: run clean

run: $(BIN)
	./$(BIN)

$(BIN): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert -f compile.f \
		--top-module frame_buf_writer_tb -o Vframe_buf_writer_tb

clean:
	rm -rf obj_dir
